//--- source/mips_pkg.sv
// widths, instruction encodings, alu operations and pipeline register types
package mips_pkg;

   localparam int unsigned XLEN       = 32;
   localparam int unsigned REG_ADDR_W = 5;

   // primary opcodes
   typedef enum logic [5:0] {
      OP_RTYPE = 6'd0,
      OP_J     = 6'd2,
      OP_BEQ   = 6'd4,
      OP_ADDI  = 6'd8,
      OP_LW    = 6'd35,
      OP_SW    = 6'd43
   } opcode_e;

   // r-type function field
   typedef enum logic [5:0] {
      FN_ADD = 6'd32,
      FN_SUB = 6'd34,
      FN_AND = 6'd36,
      FN_OR  = 6'd37,
      FN_SLT = 6'd42
   } funct_e;

   typedef enum logic [3:0] {
      ALU_AND = 4'd0,
      ALU_OR  = 4'd1,
      ALU_ADD = 4'd2,
      ALU_SUB = 4'd6,
      ALU_SLT = 4'd7
   } alu_op_e;

   typedef struct packed {
      logic reg_write;
      logic reg_dst;
      logic alu_src;
      logic mem_read;
      logic mem_write;
      logic mem_to_reg;
      logic branch;
   } ctrl_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      logic [XLEN-1:0]       pc_plus_4;
      logic [XLEN-1:0]       rs_data;
      logic [XLEN-1:0]       rt_data;
      logic [XLEN-1:0]       imm;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [5:0]            funct;
   } id_ex_t;

   typedef struct packed {
      logic                  reg_write;
      logic                  mem_read;
      logic                  mem_write;
      logic                  mem_to_reg;
      logic [XLEN-1:0]       alu_result;
      logic [XLEN-1:0]       store_data;
      logic [REG_ADDR_W-1:0] dest;
   } ex_mem_t;

endpackage

//--- source/regfile_if.sv
// register file read and write port bundle with decode, writeback, snoop and regfile modports
`timescale 1ns/1ps

interface regfile_if;

   logic [mips_pkg::REG_ADDR_W-1:0] rs_addr;
   logic [mips_pkg::REG_ADDR_W-1:0] rt_addr;
   logic [mips_pkg::XLEN-1:0]       rs_data;
   logic [mips_pkg::XLEN-1:0]       rt_data;
   logic                            wr_en;
   logic [mips_pkg::REG_ADDR_W-1:0] wr_addr;
   logic [mips_pkg::XLEN-1:0]       wr_data;

   modport decode    (output rs_addr, rt_addr, input rs_data, rt_data);
   modport writeback (output wr_en, wr_addr, wr_data);
   modport snoop     (input wr_en, wr_addr, wr_data);
   modport regfile   (input rs_addr, rt_addr, wr_en, wr_addr, wr_data,
                      output rs_data, rt_data);

endinterface

//--- source/mips_regfile.sv
// 32-entry register file with write-first reads and the led mirror register
`timescale 1ns/1ps

module mips_regfile #(
   parameter int unsigned LED_REG = 3
) (
   input  logic              clk,
   input  logic              rst_n,
   regfile_if.regfile        rf,
   output logic [7:0]        led_o
);

   localparam logic [mips_pkg::REG_ADDR_W-1:0] LED_ADDR = LED_REG[mips_pkg::REG_ADDR_W-1:0];

   logic [mips_pkg::XLEN-1:0] regs [32];
   logic                      wr_live;

   // r0 is never written
   assign wr_live = rf.wr_en && (rf.wr_addr != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
         led_o <= '0;
      end else if (wr_live) begin
         regs[rf.wr_addr] <= rf.wr_data;
         if (rf.wr_addr == LED_ADDR) begin
            led_o <= rf.wr_data[7:0];
         end
      end
   end

   // write-first bypass
   assign rf.rs_data = (wr_live && rf.wr_addr == rf.rs_addr) ? rf.wr_data : regs[rf.rs_addr];
   assign rf.rt_data = (wr_live && rf.wr_addr == rf.rt_addr) ? rf.wr_data : regs[rf.rt_addr];

endmodule

//--- source/fetch_stage.sv
// program counter, next-pc selection and the if/id register
`timescale 1ns/1ps

module fetch_stage (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [mips_pkg::XLEN-1:0] imem_data_i,
   input  logic                      stall_i,
   input  logic                      jump_i,
   input  logic [mips_pkg::XLEN-1:0] jump_target_i,
   input  logic                      branch_i,
   input  logic [mips_pkg::XLEN-1:0] branch_target_i,
   output logic [mips_pkg::XLEN-1:0] imem_addr_o,
   output logic [mips_pkg::XLEN-1:0] instr_o,
   output logic [mips_pkg::XLEN-1:0] pc_plus_4_o
);

   logic [mips_pkg::XLEN-1:0] pc_q;
   logic [mips_pkg::XLEN-1:0] pc_seq;
   logic [mips_pkg::XLEN-1:0] pc_next;

   // word addressed, so the sequential step is one
   assign pc_seq      = pc_q + 1'b1;
   assign imem_addr_o = pc_q;

   always_comb begin
      if (branch_i) begin
         pc_next = branch_target_i;
      end else if (jump_i) begin
         pc_next = jump_target_i;
      end else if (stall_i) begin
         pc_next = pc_q;
      end else begin
         pc_next = pc_seq;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q        <= '0;
         instr_o     <= '0;
         pc_plus_4_o <= '0;
      end else begin
         pc_q <= pc_next;
         // all-zero word decodes as a no-op
         if (branch_i || jump_i) begin
            instr_o     <= '0;
            pc_plus_4_o <= '0;
         end else if (!stall_i) begin
            instr_o     <= imem_data_i;
            pc_plus_4_o <= pc_seq;
         end
      end
   end

endmodule

//--- source/decode_stage.sv
// main control decode, jump handling, load-use detection and the id/ex register
`timescale 1ns/1ps

module decode_stage (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [mips_pkg::XLEN-1:0] instr_i,
   input  logic [mips_pkg::XLEN-1:0] pc_plus_4_i,
   input  logic                      flush_i,
   regfile_if.decode                 rf,
   output logic                      stall_o,
   output logic                      jump_o,
   output logic [mips_pkg::XLEN-1:0] jump_target_o,
   output mips_pkg::id_ex_t          id_ex_o
);

   logic [5:0]                      opcode;
   logic [5:0]                      funct;
   logic [mips_pkg::REG_ADDR_W-1:0] rs;
   logic [mips_pkg::REG_ADDR_W-1:0] rt;
   logic [mips_pkg::REG_ADDR_W-1:0] rd;
   logic                            funct_ok;
   logic                            uses_rs;
   logic                            uses_rt;
   mips_pkg::ctrl_t                 ctrl;
   mips_pkg::id_ex_t                id_ex_d;

   assign opcode = instr_i[31:26];
   assign rs     = instr_i[25:21];
   assign rt     = instr_i[20:16];
   assign rd     = instr_i[15:11];
   assign funct  = instr_i[5:0];

   assign rf.rs_addr = rs;
   assign rf.rt_addr = rt;

   always_comb begin
      case (funct)
         mips_pkg::FN_ADD, mips_pkg::FN_SUB, mips_pkg::FN_AND,
         mips_pkg::FN_OR, mips_pkg::FN_SLT: funct_ok = 1'b1;
         default:                           funct_ok = 1'b0;
      endcase
   end

   // unknown opcodes and functs leave every flag low
   always_comb begin
      ctrl = '0;
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            ctrl.reg_write = funct_ok;
            ctrl.reg_dst   = funct_ok;
         end
         mips_pkg::OP_ADDI: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         mips_pkg::OP_LW: begin
            ctrl.reg_write  = 1'b1;
            ctrl.alu_src    = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.mem_to_reg = 1'b1;
         end
         mips_pkg::OP_SW: begin
            ctrl.alu_src   = 1'b1;
            ctrl.mem_write = 1'b1;
         end
         mips_pkg::OP_BEQ: ctrl.branch = 1'b1;
         default:          ctrl = '0;
      endcase
   end

   // j and no-ops read nothing
   assign uses_rs = |ctrl;
   assign uses_rt = ctrl.reg_dst | ctrl.mem_write | ctrl.branch;

   assign stall_o = id_ex_o.ctrl.mem_read && (id_ex_o.rt != '0) &&
                    ((uses_rs && rs == id_ex_o.rt) || (uses_rt && rt == id_ex_o.rt));

   assign jump_o        = (opcode == mips_pkg::OP_J);
   assign jump_target_o = {pc_plus_4_i[mips_pkg::XLEN-1:26], instr_i[25:0]};

   always_comb begin
      id_ex_d.ctrl      = ctrl;
      id_ex_d.pc_plus_4 = pc_plus_4_i;
      id_ex_d.rs_data   = rf.rs_data;
      id_ex_d.rt_data   = rf.rt_data;
      id_ex_d.imm       = {{(mips_pkg::XLEN-16){instr_i[15]}}, instr_i[15:0]};
      id_ex_d.rs        = rs;
      id_ex_d.rt        = rt;
      id_ex_d.rd        = rd;
      id_ex_d.funct     = funct;
   end

   always_ff @(posedge clk) begin
      if (!rst_n || stall_o || flush_i) begin
         id_ex_o <= '0;
      end else begin
         id_ex_o <= id_ex_d;
      end
   end

endmodule

//--- source/execute_stage.sv
// operand forwarding, alu control, alu, beq resolution and the ex/mem register
`timescale 1ns/1ps

module execute_stage (
   input  logic                      clk,
   input  logic                      rst_n,
   input  mips_pkg::id_ex_t          id_ex_i,
   regfile_if.snoop                  wb,
   output logic                      branch_o,
   output logic [mips_pkg::XLEN-1:0] branch_target_o,
   output mips_pkg::ex_mem_t         ex_mem_o
);

   logic [mips_pkg::XLEN-1:0]       op_a;
   logic [mips_pkg::XLEN-1:0]       rt_fwd;
   logic [mips_pkg::XLEN-1:0]       op_b;
   logic [mips_pkg::XLEN-1:0]       alu_result;
   logic [mips_pkg::REG_ADDR_W-1:0] dest;
   logic                            mem_fwd_ok;
   logic                            wb_fwd_ok;
   logic                            slt_bit;
   mips_pkg::alu_op_e               alu_op;
   mips_pkg::ex_mem_t               ex_mem_d;

   // a load in ex/mem has no result yet, the stall covers that case
   assign mem_fwd_ok = ex_mem_o.reg_write && !ex_mem_o.mem_read && (ex_mem_o.dest != '0);
   assign wb_fwd_ok  = wb.wr_en && (wb.wr_addr != '0);

   always_comb begin
      if (mem_fwd_ok && ex_mem_o.dest == id_ex_i.rs) begin
         op_a = ex_mem_o.alu_result;
      end else if (wb_fwd_ok && wb.wr_addr == id_ex_i.rs) begin
         op_a = wb.wr_data;
      end else begin
         op_a = id_ex_i.rs_data;
      end
   end

   always_comb begin
      if (mem_fwd_ok && ex_mem_o.dest == id_ex_i.rt) begin
         rt_fwd = ex_mem_o.alu_result;
      end else if (wb_fwd_ok && wb.wr_addr == id_ex_i.rt) begin
         rt_fwd = wb.wr_data;
      end else begin
         rt_fwd = id_ex_i.rt_data;
      end
   end

   assign op_b = id_ex_i.ctrl.alu_src ? id_ex_i.imm : rt_fwd;

   // alu control, r-type takes the funct field
   always_comb begin
      alu_op = mips_pkg::ALU_ADD;
      if (id_ex_i.ctrl.branch) begin
         alu_op = mips_pkg::ALU_SUB;
      end else if (id_ex_i.ctrl.reg_dst) begin
         case (id_ex_i.funct)
            mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
            mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
            mips_pkg::FN_OR:  alu_op = mips_pkg::ALU_OR;
            mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
            default:          alu_op = mips_pkg::ALU_ADD;
         endcase
      end
   end

   assign slt_bit = $signed(op_a) < $signed(op_b);

   always_comb begin
      case (alu_op)
         mips_pkg::ALU_AND: alu_result = op_a & op_b;
         mips_pkg::ALU_OR:  alu_result = op_a | op_b;
         mips_pkg::ALU_SUB: alu_result = op_a - op_b;
         mips_pkg::ALU_SLT: alu_result = {{(mips_pkg::XLEN-1){1'b0}}, slt_bit};
         default:           alu_result = op_a + op_b;
      endcase
   end

   assign branch_o        = id_ex_i.ctrl.branch && (alu_result == '0);
   assign branch_target_o = id_ex_i.pc_plus_4 + id_ex_i.imm;

   assign dest = id_ex_i.ctrl.reg_dst ? id_ex_i.rd : id_ex_i.rt;

   always_comb begin
      ex_mem_d.reg_write  = id_ex_i.ctrl.reg_write;
      ex_mem_d.mem_read   = id_ex_i.ctrl.mem_read;
      ex_mem_d.mem_write  = id_ex_i.ctrl.mem_write;
      ex_mem_d.mem_to_reg = id_ex_i.ctrl.mem_to_reg;
      ex_mem_d.alu_result = alu_result;
      ex_mem_d.store_data = rt_fwd;
      ex_mem_d.dest       = dest;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem_o <= '0;
      end else begin
         ex_mem_o <= ex_mem_d;
      end
   end

endmodule

//--- source/memory_stage.sv
// data memory, the mem/wb register and the write-back select
`timescale 1ns/1ps

module memory_stage #(
   parameter int unsigned DMEM_WORDS = 64
) (
   input  logic              clk,
   input  logic              rst_n,
   input  mips_pkg::ex_mem_t ex_mem_i,
   regfile_if.writeback      wb
);

   logic [mips_pkg::XLEN-1:0]       dmem [DMEM_WORDS];
   logic [mips_pkg::XLEN-1:0]       dmem_addr;
   logic [mips_pkg::XLEN-1:0]       load_q;
   logic [mips_pkg::XLEN-1:0]       alu_q;
   logic [mips_pkg::REG_ADDR_W-1:0] dest_q;
   logic                            reg_write_q;
   logic                            mem_to_reg_q;

   // word index wraps at the memory depth
   assign dmem_addr = ex_mem_i.alu_result % DMEM_WORDS;

   always_ff @(posedge clk) begin
      if (ex_mem_i.mem_write) begin
         dmem[dmem_addr] <= ex_mem_i.store_data;
      end
      if (ex_mem_i.mem_read) begin
         load_q <= dmem[dmem_addr];
      end
      alu_q <= ex_mem_i.alu_result;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         reg_write_q  <= 1'b0;
         mem_to_reg_q <= 1'b0;
         dest_q       <= '0;
      end else begin
         reg_write_q  <= ex_mem_i.reg_write;
         mem_to_reg_q <= ex_mem_i.mem_to_reg;
         dest_q       <= ex_mem_i.dest;
      end
   end

   assign wb.wr_en   = reg_write_q;
   assign wb.wr_addr = dest_q;
   assign wb.wr_data = mem_to_reg_q ? load_q : alu_q;

endmodule

//--- source/mips_core.sv
// five-stage pipelined core top level, stages and register file
`timescale 1ns/1ps

module mips_core #(
   parameter int unsigned DMEM_WORDS = 64,
   parameter int unsigned LED_REG    = 3
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [mips_pkg::XLEN-1:0] imem_data_i,
   output logic [mips_pkg::XLEN-1:0] imem_addr_o,
   output logic [7:0]                led_o
);

   logic [mips_pkg::XLEN-1:0] instr;
   logic [mips_pkg::XLEN-1:0] pc_plus_4;
   logic                      stall;
   logic                      jump;
   logic [mips_pkg::XLEN-1:0] jump_target;
   logic                      branch;
   logic [mips_pkg::XLEN-1:0] branch_target;
   mips_pkg::id_ex_t          id_ex;
   mips_pkg::ex_mem_t         ex_mem;

   regfile_if rf_bus ();

   fetch_stage u_fetch (
      .clk             (clk),
      .rst_n           (rst_n),
      .imem_data_i     (imem_data_i),
      .stall_i         (stall),
      .jump_i          (jump),
      .jump_target_i   (jump_target),
      .branch_i        (branch),
      .branch_target_i (branch_target),
      .imem_addr_o     (imem_addr_o),
      .instr_o         (instr),
      .pc_plus_4_o     (pc_plus_4)
   );

   decode_stage u_decode (
      .clk           (clk),
      .rst_n         (rst_n),
      .instr_i       (instr),
      .pc_plus_4_i   (pc_plus_4),
      .flush_i       (branch),
      .rf            (rf_bus.decode),
      .stall_o       (stall),
      .jump_o        (jump),
      .jump_target_o (jump_target),
      .id_ex_o       (id_ex)
   );

   execute_stage u_execute (
      .clk             (clk),
      .rst_n           (rst_n),
      .id_ex_i         (id_ex),
      .wb              (rf_bus.snoop),
      .branch_o        (branch),
      .branch_target_o (branch_target),
      .ex_mem_o        (ex_mem)
   );

   memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_mem_i (ex_mem),
      .wb       (rf_bus.writeback)
   );

   mips_regfile #(.LED_REG(LED_REG)) u_regfile (
      .clk   (clk),
      .rst_n (rst_n),
      .rf    (rf_bus.regfile),
      .led_o (led_o)
   );

endmodule

//--- sim/mips_props.sv
// concurrent checks on the core pc, stall and led behavior
`timescale 1ns/1ps

module mips_props #(
   parameter int unsigned LED_REG = 3
) (
   input logic        clk,
   input logic        rst_n,
   input logic        stall_i,
   input logic        jump_i,
   input logic        branch_i,
   input logic [31:0] pc_i,
   input logic [7:0]  led_i,
   input logic        wr_en_i,
   input logic [4:0]  wr_addr_i
);

   // failed property count
   int failures = 0;

   // a stall without a redirect holds the pc
   assert property (@(posedge clk) disable iff (!rst_n)
      (stall_i && !jump_i && !branch_i) |=> $stable(pc_i))
      else begin
         $error("pc moved during a load-use stall");
         failures++;
      end

   assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(pc_i))
      else begin
         $error("instruction address is unknown after reset");
         failures++;
      end

   // led register loads only on a write to LED_REG
   assert property (@(posedge clk) disable iff (!rst_n)
      $changed(led_i) |-> $past(wr_en_i && wr_addr_i == LED_REG[4:0]))
      else begin
         $error("led_o changed without a register write to the led register");
         failures++;
      end

endmodule

//--- sim/mips_tb.sv
// pipelined core testbench with clock, reset, program rom, reference model and led checker
`timescale 1ns/1ps

module mips_tb;

   localparam int unsigned DMEM_WORDS = 64;
   localparam int unsigned LED_REG    = 3;
   localparam int PROG_WORDS   = 64;
   localparam int RESET_CYCLES = 16;
   localparam int WAIT_LIMIT   = 2000;
   localparam int QUIET_CYCLES = 24;

   logic        clk;
   logic        rst_n;
   logic [31:0] imem_data;
   logic [31:0] imem_addr;
   logic [7:0]  led;
   logic [31:0] prog [PROG_WORDS];
   logic [7:0]  exp_q [$];
   logic [7:0]  seen_led;
   logic        checking;
   string       test_name;
   int          pc_w;
   int          seed;

   mips_core #(.DMEM_WORDS(DMEM_WORDS), .LED_REG(LED_REG)) dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .imem_data_i (imem_data),
      .imem_addr_o (imem_addr),
      .led_o       (led)
   );

   bind mips_core mips_props #(.LED_REG(LED_REG)) u_props (
      .clk       (clk),
      .rst_n     (rst_n),
      .stall_i   (stall),
      .jump_i    (jump),
      .branch_i  (branch),
      .pc_i      (imem_addr_o),
      .led_i     (led_o),
      .wr_en_i   (rf_bus.wr_en),
      .wr_addr_i (rf_bus.wr_addr)
   );

   function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rd, input int rs,
                                         input int rt);
      return {6'd0, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, input int rs,
                                         input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] enc_j(input logic [31:0] target);
      return {mips_pkg::OP_J, target[25:0]};
   endfunction

   // words outside the program spin on a self-jump
   function automatic logic [31:0] instr_at(input logic [31:0] addr);
      if (addr < PROG_WORDS) begin
         return prog[addr];
      end
      return enc_j(addr);
   endfunction

   function automatic logic [5:0] funct_of(input logic [2:0] k);
      case (k)
         3'd0:    return mips_pkg::FN_ADD;
         3'd1:    return mips_pkg::FN_SUB;
         3'd2:    return mips_pkg::FN_AND;
         3'd3:    return mips_pkg::FN_OR;
         default: return mips_pkg::FN_SLT;
      endcase
   endfunction

   function automatic int pick_reg();
      return 1 + ($unsigned($random(seed)) % 5);
   endfunction

   // instruction-set model collecting each new low byte of register 3
   function automatic logic ref_run();
      logic [31:0] regs [32] = '{default: '0};
      logic [31:0] mem [DMEM_WORDS] = '{default: '0};
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic [31:0] next_pc;
      logic [4:0]  dst;
      logic [7:0]  last_led;
      logic        wr;
      exp_q.delete();
      pc = '0;
      last_led = '0;
      for (int step = 0; step < WAIT_LIMIT; step++) begin
         ins = instr_at(pc);
         a = regs[ins[25:21]];
         b = regs[ins[20:16]];
         imm = {{16{ins[15]}}, ins[15:0]};
         next_pc = pc + 1;
         wr = 1'b0;
         dst = ins[20:16];
         res = '0;
         case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
               dst = ins[15:11];
               wr = 1'b1;
               case (ins[5:0])
                  mips_pkg::FN_ADD: res = a + b;
                  mips_pkg::FN_SUB: res = a - b;
                  mips_pkg::FN_AND: res = a & b;
                  mips_pkg::FN_OR:  res = a | b;
                  mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default:          wr = 1'b0;
               endcase
            end
            mips_pkg::OP_ADDI: begin
               wr = 1'b1;
               res = a + imm;
            end
            mips_pkg::OP_LW: begin
               wr = 1'b1;
               res = mem[(a + imm) % DMEM_WORDS];
            end
            mips_pkg::OP_SW:  mem[(a + imm) % DMEM_WORDS] = b;
            mips_pkg::OP_BEQ: if (a == b) next_pc = pc + 1 + imm;
            mips_pkg::OP_J: begin
               next_pc = {next_pc[31:26], ins[25:0]};
               if (next_pc == pc) return 1'b1;
            end
            default: ;
         endcase
         if (wr && dst != 0) begin
            regs[dst] = res;
            if (dst == LED_REG && res[7:0] != last_led) begin
               exp_q.push_back(res[7:0]);
               last_led = res[7:0];
            end
         end
         pc = next_pc;
      end
      return 1'b0;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic clear_program();
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = enc_j(i);
      end
      pc_w = 0;
   endtask

   task automatic emit(input logic [31:0] word);
      prog[pc_w] = word;
      pc_w++;
   endtask

   task automatic build_random_program();
      int r;
      clear_program();
      for (int k = 1; k <= 5; k++) begin
         emit(enc_i(mips_pkg::OP_ADDI, k, 0, $random(seed)));
      end
      for (int n = 0; n < 24; n++) begin
         r = $random(seed);
         if (r[2:0] >= 3'd5) begin
            emit(enc_i(mips_pkg::OP_ADDI, pick_reg(), pick_reg(), r[31:16]));
         end else begin
            emit(enc_r(funct_of(r[2:0]), pick_reg(), pick_reg(), pick_reg()));
         end
      end
      emit(enc_j(pc_w));
   endtask

   task automatic run_test(input string name);
      int   cycles;
      logic ref_ok;
      @(negedge clk);
      rst_n = 1'b0;
      checking = 1'b0;
      test_name = name;
      ref_ok = ref_run();
      assert (ref_ok)
         else stop_on_error($sformatf("reference model for test %s never reached its self-jump",
                                      name));
      seen_led = 8'h00;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(negedge clk);
      end
      rst_n = 1'b1;
      checking = 1'b1;
      cycles = 0;
      while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      assert (exp_q.size() == 0)
         else stop_on_error($sformatf("test %s hung, %0d LED values still missing after %0d cycles",
                                      name, exp_q.size(), cycles));
      // a late stray write to register 3 still shows up here
      cycles = 0;
      while (cycles < QUIET_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      checking = 1'b0;
   endtask

   initial begin : clock_gen
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // combinational instruction port refreshed on the falling edge
   initial begin : imem_drive
      forever begin
         @(negedge clk);
         imem_data = instr_at(imem_addr);
      end
   end

   initial begin : compare_led
      logic [7:0] want;
      forever begin
         @(negedge clk);
         assert (dut.u_props.failures == 0)
            else stop_on_error($sformatf("test %s: a concurrent assertion on the core failed",
                                         test_name));
         if (checking && led !== seen_led) begin
            assert (exp_q.size() != 0)
               else stop_on_error($sformatf("test %s: led_o changed to %02h when no change was due",
                                            test_name, led));
            want = exp_q.pop_front();
            assert (led === want)
               else stop_on_error($sformatf("** Error test %s: expected led_o %02h, actual %02h",
                                            test_name, want, led));
            seen_led = led;
         end
      end
   end

   initial begin : main_flow
      seed = 32'hde8e6a5a;
      rst_n = 1'b0;
      imem_data = '0;
      checking = 1'b0;
      seen_led = '0;
      test_name = "";

      clear_program();
      emit(enc_i(mips_pkg::OP_ADDI, 1, 0, 'h15));
      emit(enc_i(mips_pkg::OP_ADDI, 2, 0, 'h0c));
      emit(enc_r(mips_pkg::FN_ADD, 3, 1, 2));
      emit(enc_r(mips_pkg::FN_SUB, 3, 3, 1));
      emit(enc_r(mips_pkg::FN_AND, 3, 3, 1));
      emit(enc_r(mips_pkg::FN_OR, 3, 3, 2));
      emit(enc_r(mips_pkg::FN_SLT, 3, 1, 3));
      emit(enc_r(mips_pkg::FN_SLT, 3, 3, 1));
      emit(enc_r(mips_pkg::FN_ADD, 4, 3, 3));
      emit(enc_r(mips_pkg::FN_ADD, 3, 4, 1));
      emit(enc_j(pc_w));
      run_test("rtype_forwarding");

      clear_program();
      emit(enc_i(mips_pkg::OP_ADDI, 1, 0, 'h5a));
      emit(enc_i(mips_pkg::OP_ADDI, 2, 0, 7));
      emit(enc_i(mips_pkg::OP_SW, 1, 2, 0));
      emit(enc_i(mips_pkg::OP_LW, 3, 2, 0));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 3, 1));
      emit(enc_i(mips_pkg::OP_SW, 3, 2, 1));
      emit(enc_i(mips_pkg::OP_LW, 4, 2, 1));
      emit(enc_r(mips_pkg::FN_ADD, 3, 4, 4));
      emit(enc_i(mips_pkg::OP_LW, 5, 2, 0));
      emit(enc_i(mips_pkg::OP_SW, 5, 2, 2));
      emit(enc_i(mips_pkg::OP_LW, 3, 2, 2));
      emit(enc_j(pc_w));
      run_test("load_use_memory");

      // taken beq over two writes, not-taken beq, then a counted loop
      clear_program();
      emit(enc_i(mips_pkg::OP_ADDI, 1, 0, 5));
      emit(enc_i(mips_pkg::OP_ADDI, 2, 0, 5));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h11));
      emit(enc_i(mips_pkg::OP_BEQ, 2, 1, 2));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h22));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h33));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h44));
      emit(enc_i(mips_pkg::OP_BEQ, 3, 1, 5));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h55));
      emit(enc_i(mips_pkg::OP_ADDI, 5, 0, 3));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 3, 1));
      emit(enc_i(mips_pkg::OP_ADDI, 5, 5, -1));
      emit(enc_i(mips_pkg::OP_BEQ, 0, 5, 1));
      emit(enc_j(10));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 3, 'h10));
      emit(enc_j(pc_w));
      run_test("branches");

      clear_program();
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h0a));
      emit(enc_j(3));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h0b));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h0c));
      emit(enc_j(6));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 0, 'h0d));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 3, 'h10));
      emit(enc_j(pc_w));
      run_test("jump");

      for (int round = 0; round < 3; round++) begin
         build_random_program();
         run_test($sformatf("random_%0d", round));
      end

      // opcode 63 and funct 63 are both undefined
      clear_program();
      emit(enc_i(mips_pkg::OP_ADDI, 1, 0, 'h21));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 1, 'h10));
      emit(enc_i(6'h3f, 3, 0, 'h77));
      emit(enc_r(6'h3f, 3, 1, 1));
      emit(enc_i(mips_pkg::OP_ADDI, 3, 3, 1));
      emit(enc_j(pc_w));
      run_test("unknown_opcode");

      @(negedge clk);
      if (dut.u_props.failures == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         stop_on_error("a concurrent assertion on the core failed");
      end
   end

endmodule

//--- filelist.f
source/mips_pkg.sv
source/regfile_if.sv
source/mips_regfile.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/mips_core.sv
sim/mips_props.sv
sim/mips_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mips_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
